// File: source/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    localparam int insWidth     = 8;
    localparam int moveIdxWidth = 4;
    localparam int stepWidth    = 3;
    localparam int wrEnWidth    = 10;
    localparam int incWidth     = 4;

    // last step of each phase, counted from 0
    localparam logic [stepWidth-1:0] fetchLastStep = 3'd2;
    localparam logic [stepWidth-1:0] shortLastStep = 3'd0; // single-word instructions
    localparam logic [stepWidth-1:0] midLastStep   = 3'd2; // one memory access
    localparam logic [stepWidth-1:0] longLastStep  = 3'd4; // operand fetch plus access

    // wrEnReg bit positions
    localparam int arIdx = 9;
    localparam int rIdx  = 8;
    localparam int pcIdx = 7;
    localparam int irIdx = 6;
    localparam int rlIdx = 5;
    localparam int rcIdx = 4;
    localparam int rpIdx = 3;
    localparam int rqIdx = 2;
    localparam int r1Idx = 1;
    localparam int acIdx = 0;

    // incReg bit positions
    localparam int pcInc = 3;
    localparam int rcInc = 2;
    localparam int rpInc = 1;
    localparam int rqInc = 0;

    // moves carry 15 in the low nibble, the move index in the high nibble
    typedef enum logic [insWidth-1:0] {
        opNop    = 8'd0,
        opEndop  = 8'd1,
        opClac   = 8'd2,
        opLdiac  = 8'd3,
        opLdac   = 8'd4,
        opStr    = 8'd5,
        opStir   = 8'd6,
        opJump   = 8'd7,
        opJmpnz  = 8'd8,
        opJmpz   = 8'd9,
        opMul    = 8'd10,
        opAdd    = 8'd11,
        opSub    = 8'd12,
        opIncac  = 8'd13,
        opMvRlAc = 8'h1F,
        opMvRpAc = 8'h2F,
        opMvRqAc = 8'h3F,
        opMvRcAc = 8'h4F,
        opMvRAc  = 8'h5F,
        opMvR1Ac = 8'h6F,
        opMvAcRp = 8'h7F,
        opMvAcRq = 8'h8F,
        opMvAcRl = 8'h9F
    } opcode_t;

    typedef enum logic [3:0] {
        nop, halt, clearAc, loadImm, loadInd, store, storeImm, jumpTaken,
        jumpSkip, aluMul, aluAdd, aluSub, aluInc, moveOut, moveIn, illegal
    } opClass_t;

    typedef enum logic [2:0] {
        aluOpClear = 3'd0,
        aluOpPass  = 3'd1,
        aluOpAdd   = 3'd2,
        aluOpSub   = 3'd3,
        aluOpMul   = 3'd4,
        aluOpInc   = 3'd5,
        aluOpIdle  = 3'd6
    } aluOp_t;

    typedef enum logic [3:0] {
        busDMem = 4'd0,
        busR    = 4'd1,
        busIr   = 4'd2,
        busRl   = 4'd3,
        busRc   = 4'd4,
        busRp   = 4'd5,
        busRq   = 4'd6,
        busR1   = 4'd7,
        busAc   = 4'd8,
        busIdle = 4'd9
    } busSel_t;

    typedef enum logic [1:0] {idle, fetch, execute, halted} phase_t;

endpackage

`default_nettype wire

// File: source/opcodeDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module opcodeDecoder (
    input  logic [ctrlPkg::insWidth-1:0]     ins,
    input  logic                             zFlag,
    output ctrlPkg::opClass_t                opClass,
    output logic [ctrlPkg::moveIdxWidth-1:0] moveIdx,
    output logic [ctrlPkg::stepWidth-1:0]    lastStep
);
    import ctrlPkg::*;

    // the only place where the jump condition is tested
    always_comb begin
        opClass = illegal;
        moveIdx = '0;
        case (ins)
            opNop:   opClass = nop;
            opEndop: opClass = halt;
            opClac:  opClass = clearAc;
            opLdiac: opClass = loadImm;
            opLdac:  opClass = loadInd;
            opStr:   opClass = store;
            opStir:  opClass = storeImm;
            opJump:  opClass = jumpTaken;
            opJmpnz: opClass = zFlag ? jumpSkip : jumpTaken;
            opJmpz:  opClass = zFlag ? jumpTaken : jumpSkip;
            opMul:   opClass = aluMul;
            opAdd:   opClass = aluAdd;
            opSub:   opClass = aluSub;
            opIncac: opClass = aluInc;
            opMvRlAc, opMvRpAc, opMvRqAc, opMvRcAc, opMvRAc, opMvR1Ac: begin
                opClass = moveOut; // AC into a register
                moveIdx = ins[insWidth-1:insWidth-moveIdxWidth];
            end
            opMvAcRp, opMvAcRq, opMvAcRl: begin
                opClass = moveIn;
                moveIdx = ins[insWidth-1:insWidth-moveIdxWidth];
            end
            default: opClass = illegal;
        endcase
    end

    always_comb begin
        case (opClass)
            loadImm, storeImm:          lastStep = longLastStep;
            loadInd, store, jumpTaken:  lastStep = midLastStep;
            default:                    lastStep = shortLastStep;
        endcase
    end

endmodule

`default_nettype wire

// File: source/stepSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stepSequencer (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             start,
    input  ctrlPkg::opClass_t                opClass,
    input  logic [ctrlPkg::moveIdxWidth-1:0] moveIdxIn,
    input  logic [ctrlPkg::stepWidth-1:0]    lastStep,
    output ctrlPkg::phase_t                  phase,
    output logic [ctrlPkg::stepWidth-1:0]    step,
    output ctrlPkg::opClass_t                curClass,
    output logic [ctrlPkg::moveIdxWidth-1:0] curMoveIdx,
    output logic                             ready,
    output logic                             done
);
    import ctrlPkg::*;

    logic [stepWidth-1:0] curLastStep;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase       <= idle;
            step        <= '0;
            curClass    <= nop;
            curMoveIdx  <= '0;
            curLastStep <= '0;
        end else begin
            case (phase)
                idle: begin
                    if (start) begin
                        phase <= fetch;
                        step  <= '0;
                    end
                end
                fetch: begin
                    if (step == fetchLastStep) begin // decode step
                        phase       <= execute;
                        step        <= '0;
                        curClass    <= opClass;
                        curMoveIdx  <= moveIdxIn;
                        curLastStep <= lastStep;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                execute: begin
                    if (curClass == halt) begin
                        phase <= halted;
                        step  <= '0;
                    end else if (curClass == illegal) begin
                        phase <= idle;
                        step  <= '0;
                    end else if (step == curLastStep) begin
                        phase <= fetch;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                default: begin
                    phase <= halted; // left only by reset
                    step  <= '0;
                end
            endcase
        end
    end

    assign ready = (phase == idle);
    assign done  = (phase == halted);

    readyDoneExclusive: assert property (
        @(posedge clk) disable iff (!rstN) !(ready && done)
    );

    // the step counter must wrap at the latched last step
    stepWithinLength: assert property (
        @(posedge clk) disable iff (!rstN) (phase == execute) |-> (step <= curLastStep)
    );

endmodule

`default_nettype wire

// File: source/controlWordGen.sv
`timescale 1ns/1ps
`default_nettype none

module controlWordGen (
    input  ctrlPkg::phase_t                  phase,
    input  logic [ctrlPkg::stepWidth-1:0]    step,
    input  ctrlPkg::opClass_t                curClass,
    input  logic [ctrlPkg::moveIdxWidth-1:0] curMoveIdx,
    input  ctrlPkg::opClass_t                opClass,
    output ctrlPkg::aluOp_t                  aluOp,
    output logic [ctrlPkg::incWidth-1:0]     incReg,
    output logic [ctrlPkg::wrEnWidth-1:0]    wrEnReg,
    output ctrlPkg::busSel_t                 busSel,
    output logic                             dMemWrEn,
    output logic                             zWrEn
);
    import ctrlPkg::*;

    always_comb begin
        aluOp    = aluOpIdle;
        incReg   = '0;
        wrEnReg  = '0;
        busSel   = busIdle;
        dMemWrEn = 1'b0;
        zWrEn    = 1'b0;
        case (phase)
            fetch: begin
                if (step == fetchLastStep) begin
                    incReg[pcInc] = 1'b1;
                    busSel        = busDMem;
                end else begin
                    wrEnReg[irIdx] = 1'b1; // memory wait plus IR load
                end
            end
            execute: begin
                case (curClass)
                    clearAc: begin
                        aluOp          = aluOpClear;
                        wrEnReg[acIdx] = 1'b1;
                        zWrEn          = 1'b1;
                    end
                    loadImm, storeImm: begin
                        if (step < 3'd2) begin
                            wrEnReg[irIdx] = 1'b1; // fetch the operand address
                        end else if (step == 3'd2) begin
                            incReg[pcInc]  = 1'b1;
                            wrEnReg[arIdx] = 1'b1;
                            busSel         = busIr;
                        end else if (curClass == loadImm) begin
                            aluOp          = aluOpPass;
                            wrEnReg[acIdx] = 1'b1;
                            zWrEn          = 1'b1;
                            busSel         = busDMem;
                        end else begin
                            dMemWrEn = 1'b1;
                        end
                    end
                    loadInd, store: begin
                        if (step == 3'd0) begin
                            wrEnReg[arIdx] = 1'b1; // address from AC
                            busSel         = busAc;
                        end else if (curClass == loadInd) begin
                            aluOp          = aluOpPass;
                            wrEnReg[acIdx] = 1'b1;
                            zWrEn          = 1'b1;
                            busSel         = busDMem;
                        end else begin
                            dMemWrEn = 1'b1;
                        end
                    end
                    jumpTaken: begin
                        if (step < 3'd2) begin
                            wrEnReg[irIdx] = 1'b1;
                            busSel         = busDMem;
                        end else begin
                            wrEnReg[pcIdx] = 1'b1; // target from IR
                            busSel         = busIr;
                        end
                    end
                    jumpSkip: incReg[pcInc] = 1'b1; // step over the target byte
                    aluMul: begin
                        aluOp          = aluOpMul;
                        incReg[rcInc]  = 1'b1;
                        incReg[rpInc]  = 1'b1;
                        incReg[rqInc]  = 1'b1;
                        wrEnReg[acIdx] = 1'b1;
                        zWrEn          = 1'b1;
                        busSel         = busR1;
                    end
                    aluAdd, aluSub, aluInc: begin
                        wrEnReg[acIdx] = 1'b1;
                        zWrEn          = 1'b1;
                        if (curClass == aluAdd) begin
                            aluOp  = aluOpAdd;
                            busSel = busR;
                        end else if (curClass == aluSub) begin
                            aluOp  = aluOpSub;
                            busSel = busRc;
                        end else begin
                            aluOp = aluOpInc;
                        end
                    end
                    moveOut: begin
                        busSel = busAc;
                        case (curMoveIdx)
                            4'd1:    wrEnReg[rlIdx] = 1'b1;
                            4'd2:    wrEnReg[rpIdx] = 1'b1;
                            4'd3:    wrEnReg[rqIdx] = 1'b1;
                            4'd4:    wrEnReg[rcIdx] = 1'b1;
                            4'd5:    wrEnReg[rIdx]  = 1'b1;
                            4'd6:    wrEnReg[r1Idx] = 1'b1;
                            default: wrEnReg        = '0;
                        endcase
                    end
                    moveIn: begin
                        aluOp          = aluOpPass;
                        wrEnReg[acIdx] = 1'b1;
                        zWrEn          = 1'b1;
                        case (curMoveIdx)
                            4'd7:    busSel = busRp;
                            4'd8:    busSel = busRq;
                            default: busSel = busRl;
                        endcase
                    end
                    halt:    busSel = busDMem;
                    default: busSel = busIdle; // nop and illegal
                endcase
            end
            halted:  busSel = busDMem;
            default: busSel = busIdle;
        endcase
    end

    always_comb begin
        assert ((wrEnReg & (wrEnReg - 1'b1)) == '0);
        assert (!(dMemWrEn && (wrEnReg != '0)));
        // a conditional jump needs a known zFlag at the decode step
        assert (!(phase == fetch && step == fetchLastStep) || !$isunknown(opClass));
    end

endmodule

`default_nettype wire

// File: source/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          start,
    input  logic [ctrlPkg::insWidth-1:0]  ins,
    input  logic                          zFlag,
    output ctrlPkg::aluOp_t               aluOp,
    output logic [ctrlPkg::incWidth-1:0]  incReg,  // {pc, rc, rp, rq}
    output logic [ctrlPkg::wrEnWidth-1:0] wrEnReg, // {ar, r, pc, ir, rl, rc, rp, rq, r1, ac}
    output ctrlPkg::busSel_t              busSel,
    output logic                          dMemWrEn,
    output logic                          zWrEn,
    output logic                          ready,
    output logic                          done
);
    import ctrlPkg::*;

    opClass_t                opClass;
    opClass_t                curClass;
    phase_t                  phase;
    logic [moveIdxWidth-1:0] moveIdx;
    logic [moveIdxWidth-1:0] curMoveIdx;
    logic [stepWidth-1:0]    lastStep;
    logic [stepWidth-1:0]    step;

    opcodeDecoder decoder (
        .ins      (ins),
        .zFlag    (zFlag),
        .opClass  (opClass),
        .moveIdx  (moveIdx),
        .lastStep (lastStep)
    );

    stepSequencer sequencer (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .opClass    (opClass),
        .moveIdxIn  (moveIdx),
        .lastStep   (lastStep),
        .phase      (phase),
        .step       (step),
        .curClass   (curClass),
        .curMoveIdx (curMoveIdx),
        .ready      (ready),
        .done       (done)
    );

    controlWordGen wordGen (
        .phase      (phase),
        .step       (step),
        .curClass   (curClass),
        .curMoveIdx (curMoveIdx),
        .opClass    (opClass), // live class, used at the decode step
        .aluOp      (aluOp),
        .incReg     (incReg),
        .wrEnReg    (wrEnReg),
        .busSel     (busSel),
        .dMemWrEn   (dMemWrEn),
        .zWrEn      (zWrEn)
    );

endmodule

`default_nettype wire

// File: tests/controlTasks.svh
localparam word_t idleWord   = {2'b10, aluOpIdle, 14'd0, busIdle, 2'b00};
localparam word_t haltedWord = {2'b01, aluOpIdle, 14'd0, busDMem, 2'b00};

function automatic logic [9:0] wrOf(input int idx);
    return 10'd1 << idx;
endfunction

function automatic logic [3:0] incOf(input int idx);
    return 4'd1 << idx;
endfunction

function automatic word_t ctrlWord(input aluOp_t alu, input logic [3:0] inc, input logic [9:0] wr,
                                   input busSel_t bus, input logic dm, input logic z);
    return {2'b00, alu, inc, wr, bus, dm, z};
endfunction

// AC load through the ALU, zero flag follows
function automatic word_t accWord(input aluOp_t alu, input busSel_t bus);
    return ctrlWord(alu, 4'd0, wrOf(acIdx), bus, 1'b0, 1'b1);
endfunction

function automatic int moveTarget(input logic [3:0] mv);
    case (mv)
        4'd1:    return rlIdx;
        4'd2:    return rpIdx;
        4'd3:    return rqIdx;
        4'd4:    return rcIdx;
        4'd5:    return rIdx;
        default: return r1Idx;
    endcase
endfunction

function automatic bit isTaken(input logic [7:0] op, input logic zf);
    return op == opJump || (op == opJmpz && zf) || (op == opJmpnz && !zf);
endfunction

function automatic int execLen(input logic [7:0] op, input logic zf);
    if (op == opLdiac || op == opStir) return 5;
    if (op == opLdac || op == opStr || isTaken(op, zf)) return 3;
    return 1;
endfunction

function automatic word_t fetchWord(input int s);
    if (s < 2) return ctrlWord(aluOpIdle, 4'd0, wrOf(irIdx), busIdle, 1'b0, 1'b0);
    return ctrlWord(aluOpIdle, incOf(pcInc), 10'd0, busDMem, 1'b0, 1'b0);
endfunction

function automatic word_t execWord(input logic [7:0] op, input logic zf, input int s);
    logic [3:0] mv;
    word_t      storeWord;
    mv        = op[7:4];
    storeWord = ctrlWord(aluOpIdle, 4'd0, 10'd0, busIdle, 1'b1, 1'b0);
    if (op[3:0] == 4'hF && mv >= 4'd7 && mv <= 4'd9)
        return accWord(aluOpPass, mv == 4'd7 ? busRp : (mv == 4'd8 ? busRq : busRl));
    if (op[3:0] == 4'hF && mv >= 4'd1 && mv <= 4'd6)
        return ctrlWord(aluOpIdle, 4'd0, wrOf(moveTarget(mv)), busAc, 1'b0, 1'b0);
    if (op == opLdiac || op == opStir) begin
        if (s < 2) return ctrlWord(aluOpIdle, 4'd0, wrOf(irIdx), busIdle, 1'b0, 1'b0);
        if (s == 2) return ctrlWord(aluOpIdle, incOf(pcInc), wrOf(arIdx), busIr, 1'b0, 1'b0);
        return op == opLdiac ? accWord(aluOpPass, busDMem) : storeWord;
    end
    if (op == opLdac || op == opStr) begin
        if (s == 0) return ctrlWord(aluOpIdle, 4'd0, wrOf(arIdx), busAc, 1'b0, 1'b0);
        return op == opLdac ? accWord(aluOpPass, busDMem) : storeWord;
    end
    if (isTaken(op, zf)) begin
        if (s < 2) return ctrlWord(aluOpIdle, 4'd0, wrOf(irIdx), busDMem, 1'b0, 1'b0);
        return ctrlWord(aluOpIdle, 4'd0, wrOf(pcIdx), busIr, 1'b0, 1'b0);
    end
    case (op)
        opJmpz, opJmpnz: return ctrlWord(aluOpIdle, incOf(pcInc), 10'd0, busIdle, 1'b0, 1'b0);
        opClac:  return accWord(aluOpClear, busIdle);
        opMul:   return ctrlWord(aluOpMul, incOf(rcInc) | incOf(rpInc) | incOf(rqInc),
                                 wrOf(acIdx), busR1, 1'b0, 1'b1);
        opAdd:   return accWord(aluOpAdd, busR);
        opSub:   return accWord(aluOpSub, busRc);
        opIncac: return accWord(aluOpInc, busIdle);
        opEndop: return ctrlWord(aluOpIdle, 4'd0, 10'd0, busDMem, 1'b0, 1'b0);
        default: return ctrlWord(aluOpIdle, 4'd0, 10'd0, busIdle, 1'b0, 1'b0); // nop, illegal
    endcase
endfunction

// noise on ins everywhere except the decode step
task automatic runOp(input logic [7:0] op, input logic zf);
    for (int s = 0; s < 3; s++) begin
        cycleCheck(s == 2 ? op : 8'($urandom), zf, 1'b0, fetchWord(s), $sformatf("fetch %h", op));
    end
    for (int s = 0; s < execLen(op, zf); s++) begin
        cycleCheck(8'($urandom), zf, 1'b0, execWord(op, zf, s), $sformatf("execute %h", op));
    end
endtask

task automatic startUnit();
    resetDut();
    cycleCheck(8'h00, 1'b0, 1'b1, idleWord, "start in idle");
endtask

task automatic testReset();
    resetDut();
    repeat (5) cycleCheck(8'($urandom), 1'b0, 1'b0, idleWord, "idle without start");
endtask

task automatic testAlu();
    startUnit();
    runOp(opAdd, 1'b0);
    runOp(opSub, 1'b0);
    runOp(opMul, 1'b0);
    runOp(opIncac, 1'b0);
    runOp(opClac, 1'b0);
    runOp(opNop, 1'b0);
endtask

task automatic testLoadStore();
    startUnit();
    runOp(opLdiac, 1'b0);
    runOp(opStir, 1'b0);
    runOp(opLdac, 1'b0);
    runOp(opStr, 1'b0);
endtask

task automatic testJumps();
    startUnit();
    for (int zf = 0; zf < 2; zf++) begin
        runOp(opJmpz, 1'(zf));
        runOp(opJmpnz, 1'(zf));
        runOp(opJump, 1'(zf));
    end
endtask

task automatic testMoves();
    startUnit();
    for (int m = 1; m <= 9; m++) begin
        runOp({4'(m), 4'hF}, 1'b0);
    end
endtask

task automatic testHaltIllegal();
    startUnit();
    runOp(opAdd, 1'b0);
    runOp(opEndop, 1'b0);
    repeat (4) cycleCheck(8'($urandom), 1'b0, 1'b1, haltedWord, "held in halted");
    startUnit();
    runOp(8'hAF, 1'b0); // move pattern with no move index
    repeat (3) cycleCheck(8'($urandom), 1'b0, 1'b0, idleWord, "idle after illegal");
endtask

// File: tests/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;
    import ctrlPkg::*;

    typedef logic [24:0] word_t; // {ready, done, aluOp, incReg, wrEnReg, busSel, dMemWrEn, zWrEn}

    localparam int timeoutCycles = 2000; // the whole sequence needs a few hundred cycles

    logic                   clk;
    logic                   rstN;
    logic                   start;
    logic [insWidth-1:0]    ins;
    logic                   zFlag;
    aluOp_t                 aluOp;
    logic [incWidth-1:0]    incReg;
    logic [wrEnWidth-1:0]   wrEnReg;
    busSel_t                busSel;
    logic                   dMemWrEn;
    logic                   zWrEn;
    logic                   ready;
    logic                   done;
    word_t                  seen;
    int                     checks = 0;
    int                     errors = 0;
    int                     cycleCount;

    controlUnit controlUnit_inst (
        .clk(clk), .rstN(rstN), .start(start), .ins(ins), .zFlag(zFlag),
        .aluOp(aluOp), .incReg(incReg), .wrEnReg(wrEnReg), .busSel(busSel),
        .dMemWrEn(dMemWrEn), .zWrEn(zWrEn), .ready(ready), .done(done)
    );

    assign seen = {ready, done, aluOp, incReg, wrEnReg, busSel, dMemWrEn, zWrEn};

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the test sequence did not finish", cycleCount);
        $display("Test failures found");
        $finish;
    end

    // called at 1 ns after a rising edge, returns at the same point of the next cycle
    task automatic cycleCheck(input logic [7:0] insVal, input logic zf, input logic st,
                              input word_t expWord, input string what);
        ins   = insVal;
        zFlag = zf;
        start = st;
        @(negedge clk); // outputs are settled here
        checks++;
        if (seen !== expWord) begin
            errors++;
            $display("MISMATCH at %0t: %s, expected %h got %h", $time, what, expWord, seen);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic resetDut();
        @(posedge clk);
        #1;
        rstN  = 1'b0;
        start = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
    endtask

    `include "controlTasks.svh"

    initial begin
        void'($urandom(39));
        rstN  = 1'b0;
        start = 1'b0;
        ins   = '0;
        zFlag = 1'b0;
        testReset();
        testAlu();
        testLoadStore();
        testJumps();
        testMoves();
        testHaltIllegal();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+tests
source/ctrlPkg.sv
source/opcodeDecoder.sv
source/stepSequencer.sv
source/controlWordGen.sv
source/controlUnit.sv
tests/controlUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module controlUnitTb -f sim.f -Mdir obj_dir

# the log decides pass or fail
./obj_dir/VcontrolUnitTb | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished, see sim.log"
